// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bpu
FILELIST  ?= build.f
BUILD_DIR ?= ./obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Regression passed

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bimodal_predictor.sv ====
module bimodal_predictor
    import bpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] lookup_pc_i,
    input  logic            update_i,
    input  logic            update_taken_i,
    input  logic [xlen-1:0] update_pc_i,
    output logic            predict_taken_o
);

    logic [1:0]             ctr_table [bht_entries];
    logic [bht_index_w-1:0] lookup_idx;
    logic [bht_index_w-1:0] update_idx;
    logic [1:0]             update_ctr;

    assign lookup_idx = lookup_pc_i[bht_index_w:1];
    assign update_idx = update_pc_i[bht_index_w:1];

    // msb of the counter gives the direction
    assign predict_taken_o = ctr_table[lookup_idx][1];

    assign update_ctr = ctr_table[update_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bht_entries; i++) begin
                ctr_table[i] <= ctr_reset_value;
            end
        end else if (update_i) begin
            if (update_taken_i) begin
                if (update_ctr != 2'b11) begin  // saturate at strongly taken
                    ctr_table[update_idx] <= update_ctr + 2'd1;
                end
            end else begin
                if (update_ctr != 2'b00) begin  // saturate at strongly not taken
                    ctr_table[update_idx] <= update_ctr - 2'd1;
                end
            end
        end
    end

endmodule

// ==== bpu_pkg.sv ====
package bpu_pkg;

    localparam int xlen = 32;

    // bimodal table, indexed by pc[9:1]
    localparam int bht_index_w = 9;
    localparam int bht_entries = 1 << bht_index_w;

    // btb, indexed by pc[9:2], tagged by pc[31:10]
    localparam int btb_index_w = 8;
    localparam int btb_entries = 1 << btb_index_w;
    localparam int btb_tag_w   = xlen - btb_index_w - 2;

    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    localparam logic [1:0] ctr_reset_value = 2'd1;  // weakly not taken

    // one fetched word, read as b-type or j-type fields
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_word_u;

endpackage

// ==== bpu_top.sv ====
module bpu_top
    import bpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] if_pc_i,
    input  logic [xlen-1:0] if_inst_i,
    input  logic            ex_branch_valid_i,
    input  logic            ex_branch_taken_i,
    input  logic [xlen-1:0] ex_pc_i,
    input  logic [xlen-1:0] ex_target_i,
    output logic            branch_or_not_o,
    output logic            pdt_res_o,
    output logic [xlen-1:0] pdt_pc_o
);

    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic [xlen-1:0] offset;
    logic            predict_taken;
    logic            btb_hit;
    logic [xlen-1:0] btb_target;

    inst_predecode inst_predecode_inst (
        .inst_i      (if_inst_i),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .offset_o    (offset)
    );

    // direction table, trained on every resolved branch
    bimodal_predictor bimodal_predictor_inst (
        .clk             (clk),
        .rst             (rst),
        .lookup_pc_i     (if_pc_i),
        .update_i        (ex_branch_valid_i),
        .update_taken_i  (ex_branch_taken_i),
        .update_pc_i     (ex_pc_i),
        .predict_taken_o (predict_taken)
    );

    branch_target_buffer branch_target_buffer_inst (
        .clk             (clk),
        .rst             (rst),
        .lookup_pc_i     (if_pc_i),
        .update_i        (ex_branch_valid_i),
        .update_taken_i  (ex_branch_taken_i),
        .update_pc_i     (ex_pc_i),
        .update_target_i (ex_target_i),
        .hit_o           (btb_hit),
        .target_o        (btb_target)
    );

    next_pc_select next_pc_select_inst (
        .pc_i            (if_pc_i),
        .is_branch_i     (is_branch),
        .is_jal_i        (is_jal),
        .is_jalr_i       (is_jalr),
        .offset_i        (offset),
        .predict_taken_i (predict_taken),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .branch_or_not_o (branch_or_not_o),
        .pdt_res_o       (pdt_res_o),
        .pdt_pc_o        (pdt_pc_o)
    );

endmodule

// ==== branch_target_buffer.sv ====
module branch_target_buffer
    import bpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] lookup_pc_i,
    input  logic            update_i,
    input  logic            update_taken_i,
    input  logic [xlen-1:0] update_pc_i,
    input  logic [xlen-1:0] update_target_i,
    output logic            hit_o,
    output logic [xlen-1:0] target_o
);

    logic                   valid_q  [btb_entries];
    logic [btb_tag_w-1:0]   tag_q    [btb_entries];
    logic [xlen-1:0]        target_q [btb_entries];

    logic [btb_index_w-1:0] lookup_idx;
    logic [btb_tag_w-1:0]   lookup_tag;
    logic [btb_index_w-1:0] update_idx;
    logic [btb_tag_w-1:0]   update_tag;
    logic                   write_en;

    // index from pc[9:2], tag from the bits above it
    assign lookup_idx = lookup_pc_i[btb_index_w+1:2];
    assign lookup_tag = lookup_pc_i[xlen-1:xlen-btb_tag_w];
    assign update_idx = update_pc_i[btb_index_w+1:2];
    assign update_tag = update_pc_i[xlen-1:xlen-btb_tag_w];

    // only taken branches allocate
    assign write_en = update_i && update_taken_i;

    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < btb_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (write_en) begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    // tag and target storage, old entry simply replaced
    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_q[update_idx]    <= update_tag;
            target_q[update_idx] <= update_target_i;
        end
    end

endmodule

// ==== build.f ====
bpu_pkg.sv
inst_predecode.sv
bimodal_predictor.sv
branch_target_buffer.sv
next_pc_select.sv
bpu_top.sv
tb_bpu.sv

// ==== inst_predecode.sv ====
module inst_predecode
    import bpu_pkg::*;
(
    input  logic [xlen-1:0] inst_i,
    output logic            is_branch_o,
    output logic            is_jal_o,
    output logic            is_jalr_o,
    output logic [xlen-1:0] offset_o
);

    inst_word_u      word;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] j_imm;

    assign word = inst_word_u'(inst_i);

    // opcode sits at the same place in both views
    assign is_branch_o = (word.b.opcode == opc_branch);
    assign is_jal_o    = (word.j.opcode == opc_jal);
    assign is_jalr_o   = (word.j.opcode == opc_jalr);

    // 13-bit branch offset, sign extended
    assign b_imm = {{(xlen-12){word.b.imm12}},
                    word.b.imm11,
                    word.b.imm10_5,
                    word.b.imm4_1,
                    1'b0};

    // 21-bit jump offset, sign extended
    assign j_imm = {{(xlen-20){word.j.imm20}},
                    word.j.imm19_12,
                    word.j.imm11,
                    word.j.imm10_1,
                    1'b0};

    // jalr has no pc-relative target, so it just gets the b view
    assign offset_o = is_jal_o ? j_imm : b_imm;

endmodule

// ==== next_pc_select.sv ====
module next_pc_select
    import bpu_pkg::*;
(
    input  logic [xlen-1:0] pc_i,
    input  logic            is_branch_i,
    input  logic            is_jal_i,
    input  logic            is_jalr_i,
    input  logic [xlen-1:0] offset_i,
    input  logic            predict_taken_i,
    input  logic            btb_hit_i,
    input  logic [xlen-1:0] btb_target_i,
    output logic            branch_or_not_o,
    output logic            pdt_res_o,
    output logic [xlen-1:0] pdt_pc_o
);

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_plus_off;
    logic [xlen-1:0] taken_target;

    assign pc_plus4    = pc_i + xlen'(4);
    assign pc_plus_off = pc_i + offset_i;

    // btb wins over the immediate when it hits
    assign taken_target = btb_hit_i ? btb_target_i : pc_plus_off;

    assign branch_or_not_o = is_branch_i || is_jal_i || is_jalr_i;

    always_comb begin
        pdt_res_o = 1'b0;
        pdt_pc_o  = pc_plus4;  // fall through
        if (is_jal_i) begin
            pdt_res_o = 1'b1;
            pdt_pc_o  = taken_target;
        end else if (is_branch_i) begin
            pdt_res_o = predict_taken_i;
            if (predict_taken_i) begin
                pdt_pc_o = taken_target;
            end
        end else if (is_jalr_i) begin
            // register target unknown here, needs a btb entry
            if (predict_taken_i && btb_hit_i) begin
                pdt_res_o = 1'b1;
                pdt_pc_o  = btb_target_i;
            end
        end
    end

endmodule

// ==== tb_bpu.sv ====
module tb_bpu
    import bpu_pkg::*;
();

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic [1:0]      upd;           // {valid, taken}
        logic [xlen-1:0] upd_pc;
        logic [xlen-1:0] upd_target;
        logic            from_model;    // expected columns filled in by the model
        logic [1:0]      expect_flags;  // {branch_or_not, pdt_res}
        logic [xlen-1:0] expect_pc;
    } step_t;

    logic            clk;
    logic            rst;
    logic [xlen-1:0] if_pc_i;
    logic [xlen-1:0] if_inst_i;
    logic            ex_branch_valid_i;
    logic            ex_branch_taken_i;
    logic [xlen-1:0] ex_pc_i;
    logic [xlen-1:0] ex_target_i;
    logic            branch_or_not_o;
    logic            pdt_res_o;
    logic [xlen-1:0] pdt_pc_o;

    step_t steps[$];
    int    cycle_count = 0;
    int    cycle_limit = 0;
    int    step_num = 0;

    // reference copies of both tables
    logic [1:0]           model_ctr    [bht_entries];
    logic                 model_valid  [btb_entries];
    logic [btb_tag_w-1:0] model_tag    [btb_entries];
    logic [xlen-1:0]      model_target [btb_entries];

    bpu_top bpu_top_inst (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc_i),
        .if_inst_i         (if_inst_i),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pc_i           (ex_pc_i),
        .ex_target_i       (ex_target_i),
        .branch_or_not_o   (branch_or_not_o),
        .pdt_res_o         (pdt_res_o),
        .pdt_pc_o          (pdt_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("Regression failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s step %0d: expected %h, got %h", name, step_num, expected, actual);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_addr(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s step %0d: expected %h, got %h", name, step_num, expected, actual);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // immediates straight from the raw bit positions of the isa
    function automatic logic [xlen-1:0] b_offset(input logic [xlen-1:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [xlen-1:0] j_offset(input logic [xlen-1:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    task automatic clear_model();
        for (int i = 0; i < bht_entries; i++) begin
            model_ctr[i] = ctr_reset_value;
        end
        for (int i = 0; i < btb_entries; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i] = '0;
            model_target[i] = '0;
        end
    endtask

    task automatic train_model(input logic [xlen-1:0] pc, input logic taken,
                               input logic [xlen-1:0] target);
        logic [8:0] ci;
        logic [7:0] ti;
        ci = pc[9:1];
        ti = pc[9:2];
        if (taken && model_ctr[ci] != 2'd3) begin
            model_ctr[ci] = model_ctr[ci] + 2'd1;
        end else if (!taken && model_ctr[ci] != 2'd0) begin
            model_ctr[ci] = model_ctr[ci] - 2'd1;
        end
        if (taken) begin
            model_valid[ti] = 1'b1;
            model_tag[ti] = pc[31:10];
            model_target[ti] = target;
        end
    endtask

    function automatic void predict_model(input logic [xlen-1:0] pc, input logic [xlen-1:0] inst,
                                          output logic [1:0] flags,
                                          output logic [xlen-1:0] npc);
        logic            ctr_taken;
        logic            hit;
        logic [xlen-1:0] stored;
        ctr_taken = model_ctr[pc[9:1]][1];
        hit = model_valid[pc[9:2]] && (model_tag[pc[9:2]] == pc[31:10]);
        stored = model_target[pc[9:2]];
        flags = 2'b00;
        npc = pc + 32'd4;
        case (inst[6:0])
            opc_jal: begin
                flags = 2'b11;
                npc = hit ? stored : pc + j_offset(inst);
            end
            opc_branch: begin
                flags = {1'b1, ctr_taken};
                if (ctr_taken) begin
                    npc = hit ? stored : pc + b_offset(inst);
                end
            end
            opc_jalr: begin
                flags = {1'b1, ctr_taken && hit};
                if (ctr_taken && hit) begin
                    npc = stored;
                end
            end
            default: ;
        endcase
    endfunction

    task automatic add_step(input logic [xlen-1:0] pc, input logic [xlen-1:0] inst,
                            input logic [1:0] upd, input logic [xlen-1:0] upd_pc,
                            input logic [xlen-1:0] upd_target, input logic [1:0] flags,
                            input logic [xlen-1:0] npc);
        step_t s;
        s = '{pc, inst, upd, upd_pc, upd_target, 1'b0, flags, npc};
        steps.push_back(s);
    endtask

    task automatic build_directed_table();
        // after reset: plain word, branch, jal
        add_step(32'h0100, 32'h0010_0093, 2'b00, 32'h0, 32'h0, 2'b00, 32'h0104);
        add_step(32'h1000, 32'h0000_0863, 2'b00, 32'h0, 32'h0, 2'b10, 32'h1004);
        add_step(32'h2000, 32'h1000_006f, 2'b00, 32'h0, 32'h0, 2'b11, 32'h2100);
        // training at 0x1000, lookup in the update cycle sees the old counter
        add_step(32'h1000, 32'h0000_0863, 2'b11, 32'h1000, 32'h3000, 2'b10, 32'h1004);
        add_step(32'h1000, 32'h0000_0863, 2'b11, 32'h1000, 32'h3000, 2'b11, 32'h3000);
        add_step(32'h1000, 32'h0000_0863, 2'b11, 32'h1000, 32'h3000, 2'b11, 32'h3000);
        add_step(32'h1000, 32'h0000_0863, 2'b10, 32'h1000, 32'h0, 2'b11, 32'h3000);
        add_step(32'h1000, 32'h0000_0863, 2'b00, 32'h0, 32'h0, 2'b11, 32'h3000);
        add_step(32'h1000, 32'h0000_0863, 2'b10, 32'h1000, 32'h0, 2'b11, 32'h3000);
        add_step(32'h1000, 32'h0000_0863, 2'b10, 32'h1000, 32'h0, 2'b10, 32'h1004);
        add_step(32'h1000, 32'h0000_0863, 2'b00, 32'h0, 32'h0, 2'b10, 32'h1004);
        add_step(32'h1000, 32'h0000_0863, 2'b11, 32'h1000, 32'h3000, 2'b10, 32'h1004);
        add_step(32'h1000, 32'h0000_0863, 2'b11, 32'h1000, 32'h3000, 2'b10, 32'h1004);
        // bit 31 set: same counter, btb tag miss
        add_step(32'h8000_1000, 32'h0000_0863, 2'b00, 32'h0, 32'h0, 2'b11, 32'h8000_1010);
        add_step(32'h1000, 32'h0000_0863, 2'b00, 32'h0, 32'h0, 2'b11, 32'h3000);
        add_step(32'h8000_1000, 32'hfe00_0ce3, 2'b00, 32'h0, 32'h0, 2'b11, 32'h8000_0ff8);
        // jal, btb entry beats the immediate
        add_step(32'h2040, 32'h1000_006f, 2'b11, 32'h2040, 32'h5000, 2'b11, 32'h2140);
        add_step(32'h2040, 32'h1000_006f, 2'b00, 32'h0, 32'h0, 2'b11, 32'h5000);
        // jalr needs counter taken and a btb hit
        add_step(32'h3080, 32'h0000_8067, 2'b00, 32'h0, 32'h0, 2'b10, 32'h3084);
        add_step(32'h3080, 32'h0000_8067, 2'b11, 32'h3080, 32'h6000, 2'b10, 32'h3084);
        add_step(32'h3080, 32'h0000_8067, 2'b00, 32'h0, 32'h0, 2'b11, 32'h6000);
        add_step(32'h8000_3080, 32'h0000_8067, 2'b00, 32'h0, 32'h0, 2'b10, 32'h8000_3084);
        add_step(32'h3080, 32'h0000_8067, 2'b10, 32'h3080, 32'h0, 2'b11, 32'h6000);
        add_step(32'h3080, 32'h0000_8067, 2'b00, 32'h0, 32'h0, 2'b10, 32'h3084);
        // plain word at a pc with a btb hit still falls through
        add_step(32'h1000, 32'h0010_0093, 2'b00, 32'h0, 32'h0, 2'b00, 32'h1004);
    endtask

    task automatic add_random_steps(input int count);
        step_t      s;
        inst_word_u w;
        int         kind;
        for (int n = 0; n < count; n++) begin
            s = '0;
            w = inst_word_u'($urandom);
            kind = $urandom_range(3, 0);
            case (kind)
                0: w.b.opcode = opc_branch;
                1: w.j.opcode = opc_jal;
                2: w.j.opcode = opc_jalr;
                default: w.b.opcode = 7'b0010011;  // op-imm
            endcase
            // small pc range, so index and tag collide often
            s.pc = $urandom & 32'h8000_043c;
            s.inst = w;
            s.upd = 2'($urandom);
            s.upd_pc = $urandom & 32'h8000_043c;
            s.upd_target = $urandom & 32'hffff_fffc;
            s.from_model = 1'b1;
            steps.push_back(s);
        end
    endtask

    task automatic run_step(input step_t s);
        logic [1:0]      flags;
        logic [xlen-1:0] npc;
        @(negedge clk);
        if_pc_i = s.pc;
        if_inst_i = s.inst;
        ex_branch_valid_i = s.upd[1];
        ex_branch_taken_i = s.upd[0];
        ex_pc_i = s.upd_pc;
        ex_target_i = s.upd_target;
        flags = s.expect_flags;
        npc = s.expect_pc;
        if (s.from_model) begin
            predict_model(s.pc, s.inst, flags, npc);
        end
        #25;
        check_flag("branch_or_not_o", flags[1], branch_or_not_o);
        check_flag("pdt_res_o", flags[0], pdt_res_o);
        check_addr("pdt_pc_o", npc, pdt_pc_o);
        @(posedge clk);
        if (s.upd[1]) begin
            train_model(s.upd_pc, s.upd[0], s.upd_target);
        end
    endtask

    initial begin
        void'($urandom(32'hb275_f38f));
        rst = 1'b1;
        if_pc_i = '0;
        if_inst_i = '0;
        ex_branch_valid_i = 1'b0;
        ex_branch_taken_i = 1'b0;
        ex_pc_i = '0;
        ex_target_i = '0;
        clear_model();
        build_directed_table();
        add_random_steps(200);
        // 16 reset cycles, one cycle per step, some slack
        cycle_limit = 16 + steps.size() + 20;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (steps[i]) begin
            step_num = i;
            run_step(steps[i]);
        end
        $display("Regression passed");
        $finish;
    end

endmodule
